// File: all.f
cache_pkg.sv
cache_ctrl.sv
cache_line_state.sv
cache_dpath.sv
cache_top.sv
tb_cache_mem.sv
tb_cache.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cache -f all.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_cache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qxF "=== PASS ==="; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: tb_cache.sv
/*
 * cache testbench
 * random request stream checked against a word model of memory and a tag shadow
 */
module tb_cache;

  localparam int cache_size   = 256;
  localparam int nblocks      = cache_size / 16;
  localparam int mem_lines    = 64;
  localparam int mem_words    = mem_lines * 4;
  localparam int num_rw       = 400;
  localparam int num_amo      = 150;
  localparam int clk_period   = 4;
  localparam int total_reqs   = nblocks * 4 + num_rw + num_amo + mem_words;
  // dirty miss with random memory delays and response back-pressure
  localparam int worst_cycles = 80;
  localparam int watchdog_time = (total_reqs + mem_words + 20) * worst_cycles * clk_period;

  logic                               clk;
  logic                               reset;
  logic                               cachereq_val;
  logic                               cachereq_rdy;
  cache_pkg::req_type_t               cachereq_type;
  logic [cache_pkg::opaque_nbits-1:0] cachereq_opaque;
  logic [cache_pkg::addr_nbits-1:0]   cachereq_addr;
  logic [cache_pkg::data_nbits-1:0]   cachereq_data;
  logic                               cacheresp_val;
  logic                               cacheresp_rdy;
  cache_pkg::req_type_t               cacheresp_type;
  logic [cache_pkg::opaque_nbits-1:0] cacheresp_opaque;
  logic [cache_pkg::data_nbits-1:0]   cacheresp_data;
  logic                               memreq_val;
  logic                               memreq_rdy;
  cache_pkg::req_type_t               memreq_type;
  logic [cache_pkg::addr_nbits-1:0]   memreq_addr;
  logic [cache_pkg::line_nbits-1:0]   memreq_data;
  logic                               memresp_val;
  logic                               memresp_rdy;
  cache_pkg::req_type_t               memresp_type;
  logic [cache_pkg::line_nbits-1:0]   memresp_data;
  logic                               load_en;
  logic [cache_pkg::addr_nbits-1:0]   load_addr;
  logic [cache_pkg::data_nbits-1:0]   load_data;
  int                                 read_count;
  int                                 write_count;

  cache_top #(.cache_size(cache_size)) dut_i (.*);

  tb_cache_mem #(.mem_lines(mem_lines)) mem_i (.*);

  // reference model: memory words plus a per-block tag shadow
  logic [cache_pkg::data_nbits-1:0]   model_mem [mem_words];
  logic                               shadow_valid [nblocks];
  logic                               shadow_dirty [nblocks];
  int                                 shadow_line [nblocks];
  int                                 exp_rd;
  int                                 exp_wr;
  logic [cache_pkg::opaque_nbits-1:0] next_opaque;

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ----------------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------------

  task automatic fail_now(input string msg);
    $display("Fail %0t: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("%s is %b, expected %b", name, got, exp));
  endtask

  task automatic check_resp(input cache_pkg::req_type_t got_type,
                            input logic [cache_pkg::opaque_nbits-1:0] got_opaque,
                            input logic [cache_pkg::data_nbits-1:0] got_data,
                            input cache_pkg::req_type_t exp_type,
                            input logic [cache_pkg::opaque_nbits-1:0] exp_opaque,
                            input logic [cache_pkg::data_nbits-1:0] exp_data);
    if (got_type !== exp_type || got_opaque !== exp_opaque || got_data !== exp_data) begin
      fail_now($sformatf("resp type %0d opaque %0d data %h, expected %0d %0d %h",
                         got_type, got_opaque, got_data, exp_type, exp_opaque, exp_data));
    end
  endtask

  task automatic check_mem_count(input int got_rd, input int got_wr,
                                 input int exp_rd_n, input int exp_wr_n);
    if (got_rd != exp_rd_n || got_wr != exp_wr_n) begin
      fail_now($sformatf("memory reads %0d writes %0d, expected %0d %0d",
                         got_rd, got_wr, exp_rd_n, exp_wr_n));
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) fail_now($sformatf("hit latency %0d cycles, expected %0d", got, exp));
  endtask

  // ----------------------------------------------------------------------------
  // model and request driver
  // ----------------------------------------------------------------------------

  // predicts response data, memory traffic and hit latency (0 means a miss)
  task automatic model_access(input cache_pkg::req_type_t t,
                              input logic [cache_pkg::addr_nbits-1:0] addr,
                              input logic [cache_pkg::data_nbits-1:0] data,
                              output logic [cache_pkg::data_nbits-1:0] exp_data,
                              output int exp_lat);
    int                           w;
    int                           line;
    int                           b;
    bit                           hit;
    logic [cache_pkg::data_nbits-1:0] old;
    w    = int'(addr >> 2);
    line = w / 4;
    b    = line % nblocks;
    old  = model_mem[w];
    hit  = shadow_valid[b] && shadow_line[b] == line;
    exp_lat = 0;
    if (t == cache_pkg::type_write_init) begin
      exp_lat = 3;
    end else if (hit) begin
      exp_lat = (t == cache_pkg::type_read || t == cache_pkg::type_write) ? 3 : 4;
    end else begin
      // victim goes back first when dirty
      if (shadow_dirty[b]) exp_wr++;
      exp_rd++;
      shadow_dirty[b] = 1'b0;
    end
    shadow_valid[b] = 1'b1;
    shadow_line[b]  = line;
    exp_data = old;
    case (t)
      cache_pkg::type_write_init: begin
        model_mem[w]    = data;
        shadow_dirty[b] = 1'b0;
        exp_data        = '0;
      end
      cache_pkg::type_write: begin
        model_mem[w]    = data;
        shadow_dirty[b] = 1'b1;
        exp_data        = '0;
      end
      cache_pkg::type_amo_add: begin
        model_mem[w]    = old + data;
        shadow_dirty[b] = 1'b1;
      end
      cache_pkg::type_amo_and: begin
        model_mem[w]    = old & data;
        shadow_dirty[b] = 1'b1;
      end
      cache_pkg::type_amo_or: begin
        model_mem[w]    = old | data;
        shadow_dirty[b] = 1'b1;
      end
      default: begin
      end
    endcase
  endtask

  // called on a falling edge, returns on a falling edge after the response
  task automatic send_req(input cache_pkg::req_type_t t,
                          input logic [cache_pkg::addr_nbits-1:0] addr,
                          input logic [cache_pkg::data_nbits-1:0] data);
    logic [cache_pkg::data_nbits-1:0] exp_data;
    int                               exp_lat;
    int                               lat;
    bit                               done;
    model_access(t, addr, data, exp_data, exp_lat);
    while (!cachereq_rdy) @(negedge clk);
    cachereq_val    = 1'b1;
    cachereq_type   = t;
    cachereq_opaque = next_opaque;
    cachereq_addr   = addr;
    cachereq_data   = data;
    @(negedge clk);
    cachereq_val = 1'b0;
    // count falling edges from acceptance to response valid
    lat = 1;
    while (!cacheresp_val) begin
      cacheresp_rdy = $urandom % 2 == 1;
      @(negedge clk);
      lat++;
    end
    if (exp_lat > 0) check_latency(lat, exp_lat);
    check_resp(cacheresp_type, cacheresp_opaque, cacheresp_data, t, next_opaque, exp_data);
    done = 1'b0;
    while (!done) begin
      cacheresp_rdy = $urandom % 3 != 0;
      done          = cacheresp_rdy;
      @(negedge clk);
    end
    cacheresp_rdy = 1'b0;
    check_mem_count(read_count, write_count, exp_rd, exp_wr);
    next_opaque++;
  endtask

  // ----------------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------------

  initial begin
    int                               op;
    logic [cache_pkg::addr_nbits-1:0] a;
    logic [cache_pkg::data_nbits-1:0] d;
    void'($urandom(79537));
    reset           = 1'b1;
    cachereq_val    = 1'b0;
    cachereq_type   = cache_pkg::type_read;
    cachereq_opaque = '0;
    cachereq_addr   = '0;
    cachereq_data   = '0;
    cacheresp_rdy   = 1'b0;
    load_en         = 1'b0;
    load_addr       = '0;
    load_data       = '0;
    exp_rd          = 0;
    exp_wr          = 0;
    next_opaque     = '0;
    for (int b = 0; b < nblocks; b++) begin
      shadow_valid[b] = 1'b0;
      shadow_dirty[b] = 1'b0;
      shadow_line[b]  = 0;
    end
    repeat (5) @(negedge clk);
    reset = 1'b0;

    check_flag("cachereq_rdy", cachereq_rdy, 1'b1);
    check_flag("cacheresp_val", cacheresp_val, 1'b0);
    check_flag("memreq_val", memreq_val, 1'b0);
    check_flag("memresp_rdy", memresp_rdy, 1'b0);

    // same random words into memory and model
    for (int w = 0; w < mem_words; w++) begin
      load_en      = 1'b1;
      load_addr    = w * 4;
      load_data    = $urandom;
      model_mem[w] = load_data;
      @(negedge clk);
    end
    load_en = 1'b0;

    // fill every cache block by write-init, whole lines at a time
    for (int w = 0; w < nblocks * 4; w++) begin
      send_req(cache_pkg::type_write_init, w * 4, model_mem[w]);
    end

    // reads and writes over four times the cache size
    for (int i = 0; i < num_rw; i++) begin
      a = ($urandom % mem_words) * 4;
      d = $urandom;
      if ($urandom % 2 == 1) send_req(cache_pkg::type_write, a, d);
      else send_req(cache_pkg::type_read, a, d);
    end

    // atomics mixed with reads that see their results
    for (int i = 0; i < num_amo; i++) begin
      a  = ($urandom % mem_words) * 4;
      d  = $urandom;
      op = $urandom % 4;
      case (op)
        0: send_req(cache_pkg::type_amo_add, a, d);
        1: send_req(cache_pkg::type_amo_and, a, d);
        2: send_req(cache_pkg::type_amo_or, a, d);
        default: send_req(cache_pkg::type_read, a, d);
      endcase
    end

    // evicted lines come back through memory here
    for (int w = 0; w < mem_words; w++) begin
      send_req(cache_pkg::type_read, w * 4, '0);
    end

    $display("=== PASS ===");
    $finish;
  end

  initial begin
    #(watchdog_time);
    $display("watchdog timeout, the cache stopped making progress");
    $display("=== FAIL ===");
    $fatal(1, "timeout");
  end

endmodule

// File: tb_cache_mem.sv
/*
 * testbench memory
 * line-wide backing store that answers refills and evictions after random delays
 */
module tb_cache_mem #(
  parameter  int mem_lines      = 64,
  localparam int line_idx_nbits = $clog2(mem_lines)
) (
  input  logic                               clk,
  input  logic                               reset,

  // preload port, one word per cycle
  input  logic                               load_en,
  input  logic [cache_pkg::addr_nbits-1:0]   load_addr,
  input  logic [cache_pkg::data_nbits-1:0]   load_data,

  input  logic                               memreq_val,
  output logic                               memreq_rdy,
  input  cache_pkg::req_type_t               memreq_type,
  input  logic [cache_pkg::addr_nbits-1:0]   memreq_addr,
  input  logic [cache_pkg::line_nbits-1:0]   memreq_data,

  output logic                               memresp_val,
  input  logic                               memresp_rdy,
  output cache_pkg::req_type_t               memresp_type,
  output logic [cache_pkg::line_nbits-1:0]   memresp_data,

  output int                                 read_count,
  output int                                 write_count
);

  logic [cache_pkg::line_nbits-1:0] lines [mem_lines];
  logic                             pending;
  logic                             pending_write;
  logic [line_idx_nbits-1:0]        pending_line;
  logic                             armed;
  int                               delay;

  // accept requests and responses on the rising edge
  always_ff @(posedge clk) begin
    if (reset) begin
      pending       <= 1'b0;
      pending_write <= 1'b0;
      pending_line  <= '0;
      read_count    <= 0;
      write_count   <= 0;
    end else begin
      if (load_en) begin
        lines[load_addr[4 +: line_idx_nbits]][load_addr[3:2]*cache_pkg::data_nbits +:
          cache_pkg::data_nbits] <= load_data;
      end
      if (memreq_val && memreq_rdy) begin
        pending       <= 1'b1;
        pending_write <= memreq_type == cache_pkg::type_write;
        pending_line  <= memreq_addr[4 +: line_idx_nbits];
        // a line write lands at once, the ack follows later
        if (memreq_type == cache_pkg::type_write) begin
          lines[memreq_addr[4 +: line_idx_nbits]] <= memreq_data;
          write_count <= write_count + 1;
        end else begin
          read_count <= read_count + 1;
        end
      end else if (memresp_val && memresp_rdy) begin
        pending <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------------
  // outputs change on the falling edge only
  // ----------------------------------------------------------------------------

  initial begin
    memreq_rdy   = 1'b0;
    memresp_val  = 1'b0;
    memresp_type = cache_pkg::type_read;
    memresp_data = '0;
    armed        = 1'b0;
    delay        = 0;
    forever begin
      @(negedge clk);
      if (reset || !pending) begin
        memresp_val = 1'b0;
        armed       = 1'b0;
        // random back-pressure on requests
        memreq_rdy  = !reset && ($urandom % 4 != 0);
      end else begin
        memreq_rdy = 1'b0;
        if (!armed) begin
          armed = 1'b1;
          delay = $urandom % 4;
        end
        if (delay == 0) begin
          memresp_val  = 1'b1;
          memresp_type = pending_write ? cache_pkg::type_write : cache_pkg::type_read;
          memresp_data = lines[pending_line];
        end else begin
          delay--;
        end
      end
    end
  end

endmodule

// File: cache_top.sv
/*
 * blocking write-back cache
 * joins the control FSM, line state bits and datapath
 */
module cache_top #(
  parameter int cache_size = 256
) (
  input  logic                               clk,
  input  logic                               reset,

  // processor request
  input  logic                               cachereq_val,
  output logic                               cachereq_rdy,
  input  cache_pkg::req_type_t               cachereq_type,
  input  logic [cache_pkg::opaque_nbits-1:0] cachereq_opaque,
  input  logic [cache_pkg::addr_nbits-1:0]   cachereq_addr,
  input  logic [cache_pkg::data_nbits-1:0]   cachereq_data,

  // processor response
  output logic                               cacheresp_val,
  input  logic                               cacheresp_rdy,
  output cache_pkg::req_type_t               cacheresp_type,
  output logic [cache_pkg::opaque_nbits-1:0] cacheresp_opaque,
  output logic [cache_pkg::data_nbits-1:0]   cacheresp_data,

  // memory request, one line
  output logic                               memreq_val,
  input  logic                               memreq_rdy,
  output cache_pkg::req_type_t               memreq_type,
  output logic [cache_pkg::addr_nbits-1:0]   memreq_addr,
  output logic [cache_pkg::line_nbits-1:0]   memreq_data,

  // memory response, one line
  // its type only tells a read from a write ack, which the FSM already knows
  input  logic                               memresp_val,
  output logic                               memresp_rdy,
  input  cache_pkg::req_type_t               memresp_type,
  input  logic [cache_pkg::line_nbits-1:0]   memresp_data
);

  localparam int idx_nbits = $clog2(cache_size / 16);

  logic                 cachereq_en;
  logic                 memresp_en;
  logic                 is_refill;
  logic                 tag_array_wen;
  logic                 tag_array_ren;
  logic                 data_array_wen;
  logic                 data_array_ren;
  logic                 read_data_reg_en;
  logic                 read_tag_reg_en;
  cache_pkg::amo_op_t   amo_op;
  cache_pkg::req_type_t req_type;
  logic [idx_nbits-1:0] idx;
  logic                 tag_match;
  logic                 is_valid;
  logic                 is_dirty;
  logic                 valid_wen;
  logic                 valid_in;
  logic                 dirty_wen;
  logic                 dirty_in;

  cache_ctrl #(.cache_size(cache_size)) ctrl_i (.*);

  cache_line_state #(.cache_size(cache_size)) line_state_i (.*);

  cache_dpath #(.cache_size(cache_size)) dpath_i (.*);

endmodule

// File: cache_dpath.sv
/*
 * cache datapath
 * request registers, tag and data arrays, atomic unit and message muxes
 */
module cache_dpath #(
  parameter  int cache_size = 256,
  localparam int nblocks    = cache_size / 16,
  localparam int idx_nbits  = $clog2(nblocks)
) (
  input  logic                                 clk,
  input  logic                                 reset,

  // message payloads
  input  cache_pkg::req_type_t                 cachereq_type,
  input  logic [cache_pkg::opaque_nbits-1:0]   cachereq_opaque,
  input  logic [cache_pkg::addr_nbits-1:0]     cachereq_addr,
  input  logic [cache_pkg::data_nbits-1:0]     cachereq_data,
  output cache_pkg::req_type_t                 cacheresp_type,
  output logic [cache_pkg::opaque_nbits-1:0]   cacheresp_opaque,
  output logic [cache_pkg::data_nbits-1:0]     cacheresp_data,
  output logic [cache_pkg::addr_nbits-1:0]     memreq_addr,
  output logic [cache_pkg::line_nbits-1:0]     memreq_data,
  input  logic [cache_pkg::line_nbits-1:0]     memresp_data,

  // control from the FSM
  input  logic                                 cachereq_en,
  input  logic                                 memresp_en,
  input  logic                                 is_refill,
  input  logic                                 tag_array_wen,
  input  logic                                 tag_array_ren,
  input  logic                                 data_array_wen,
  input  logic                                 data_array_ren,
  input  logic                                 read_data_reg_en,
  input  logic                                 read_tag_reg_en,
  input  cache_pkg::amo_op_t                   amo_op,
  input  cache_pkg::req_type_t                 memreq_type,

  // status to the FSM
  output cache_pkg::req_type_t                 req_type,
  output logic [idx_nbits-1:0]                 idx,
  output logic                                 tag_match
);

  localparam int dw         = cache_pkg::data_nbits;
  localparam int lw         = cache_pkg::line_nbits;
  localparam int nbytes     = lw / 8;
  localparam int tag_nbits  = cache_pkg::addr_nbits - 4 - idx_nbits;

  // ----------------------------------------------------------------------------
  // request registers
  // ----------------------------------------------------------------------------

  logic [cache_pkg::opaque_nbits-1:0] opaque_reg;
  logic [cache_pkg::addr_nbits-1:0]   addr_reg;
  logic [dw-1:0]                      data_reg;
  logic [lw-1:0]                      memresp_reg;

  // request type, decoded by the FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      req_type <= cache_pkg::type_read;
    end else if (cachereq_en) begin
      req_type <= cachereq_type;
    end
  end

  always_ff @(posedge clk) begin
    if (cachereq_en) begin
      opaque_reg <= cachereq_opaque;
      addr_reg   <= cachereq_addr;
      data_reg   <= cachereq_data;
    end
    if (memresp_en) memresp_reg <= memresp_data;
  end

  // address fields: tag | index | word offset | byte offset
  logic [tag_nbits-1:0] req_tag;
  logic [1:0]           offset;

  assign req_tag = addr_reg[cache_pkg::addr_nbits-1 -: tag_nbits];
  assign idx     = addr_reg[4 +: idx_nbits];
  assign offset  = addr_reg[3:2];

  // ----------------------------------------------------------------------------
  // tag and data arrays
  // ----------------------------------------------------------------------------

  logic [tag_nbits-1:0] tag_array [nblocks];
  logic [lw-1:0]        data_array [nblocks];
  logic [tag_nbits-1:0] tag_rd;
  logic [lw-1:0]        line_rd;

  // read ports drive zero when not enabled
  assign tag_rd    = tag_array_ren ? tag_array[idx] : '0;
  assign line_rd   = data_array_ren ? data_array[idx] : '0;
  assign tag_match = tag_array_ren && (tag_rd == req_tag);

  logic [nbytes-1:0] wben;
  logic [dw-1:0]     write_word;
  logic [lw-1:0]     write_line;

  // a refill fills the whole line, otherwise only the addressed word
  always_comb begin
    wben = '0;
    if (is_refill) begin
      wben = '1;
    end else begin
      wben[offset*4 +: 4] = 4'hf;
    end
  end

  assign write_line = is_refill ? memresp_reg : {cache_pkg::words_per_line{write_word}};

  always_ff @(posedge clk) begin
    if (tag_array_wen) tag_array[idx] <= req_tag;
    if (data_array_wen) begin
      for (int b = 0; b < nbytes; b++) begin
        if (wben[b]) data_array[idx][b*8 +: 8] <= write_line[b*8 +: 8];
      end
    end
  end

  // ----------------------------------------------------------------------------
  // read registers and atomic unit
  // ----------------------------------------------------------------------------

  logic [lw-1:0]        read_line_reg;
  logic [tag_nbits-1:0] victim_tag_reg;
  logic [dw-1:0]        old_word;

  // one register serves the read word, the atomic operand and the victim line
  always_ff @(posedge clk) begin
    if (read_data_reg_en) read_line_reg <= line_rd;
    if (read_tag_reg_en) victim_tag_reg <= tag_rd;
  end

  assign old_word = read_line_reg[offset*dw +: dw];

  // plain writes pass the request word straight through
  always_comb begin
    case (amo_op)
      cache_pkg::amo_add: write_word = old_word + data_reg;
      cache_pkg::amo_and: write_word = old_word & data_reg;
      cache_pkg::amo_or:  write_word = old_word | data_reg;
      default:            write_word = data_reg;
    endcase
  end

  // ----------------------------------------------------------------------------
  // message muxes
  // ----------------------------------------------------------------------------

  // line-aligned, victim tag for evictions and request tag for refills
  assign memreq_addr = (memreq_type == cache_pkg::type_write) ?
                       {victim_tag_reg, idx, 4'b0} : {req_tag, idx, 4'b0};
  assign memreq_data = read_line_reg;

  assign cacheresp_type   = req_type;
  assign cacheresp_opaque = opaque_reg;
  // writes answer with zero, reads and atomics with the stored old word
  assign cacheresp_data   = (req_type == cache_pkg::type_write ||
                             req_type == cache_pkg::type_write_init) ? '0 : old_word;

endmodule

// File: cache_line_state.sv
/*
 * cache line state
 * one valid and one dirty bit per block, read at the current index
 */
module cache_line_state #(
  parameter  int cache_size = 256,
  localparam int nblocks    = cache_size / 16,
  localparam int idx_nbits  = $clog2(nblocks)
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [idx_nbits-1:0] idx,
  input  logic                 valid_wen,
  input  logic                 valid_in,
  input  logic                 dirty_wen,
  input  logic                 dirty_in,
  output logic                 is_valid,
  output logic                 is_dirty
);

  logic [nblocks-1:0] valid_bits;
  logic [nblocks-1:0] dirty_bits;

  // every block starts empty and clean
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (valid_wen) valid_bits[idx] <= valid_in;
      if (dirty_wen) dirty_bits[idx] <= dirty_in;
    end
  end

  // combinational read so tag check decides in the same cycle
  assign is_valid = valid_bits[idx];
  assign is_dirty = dirty_bits[idx];

endmodule

// File: cache_ctrl.sv
/*
 * blocking cache control FSM
 * sequences tag check, data access, refill, eviction and atomics
 */
module cache_ctrl #(
  parameter int cache_size = 256
) (
  input  logic                 clk,
  input  logic                 reset,

  // message handshakes
  input  logic                 cachereq_val,
  output logic                 cachereq_rdy,
  output logic                 cacheresp_val,
  input  logic                 cacheresp_rdy,
  output logic                 memreq_val,
  input  logic                 memreq_rdy,
  input  logic                 memresp_val,
  output logic                 memresp_rdy,

  // datapath control
  output logic                 cachereq_en,
  output logic                 memresp_en,
  output logic                 is_refill,
  output logic                 tag_array_wen,
  output logic                 tag_array_ren,
  output logic                 data_array_wen,
  output logic                 data_array_ren,
  output logic                 read_data_reg_en,
  output logic                 read_tag_reg_en,
  output cache_pkg::amo_op_t   amo_op,
  output cache_pkg::req_type_t memreq_type,

  // datapath status
  input  cache_pkg::req_type_t req_type,
  input  logic                 tag_match,

  // line state
  input  logic                 is_valid,
  input  logic                 is_dirty,
  output logic                 valid_wen,
  output logic                 valid_in,
  output logic                 dirty_wen,
  output logic                 dirty_in
);

  // ----------------------------------------------------------------------------
  // state encoding
  // ----------------------------------------------------------------------------

  localparam logic [3:0] st_idle          = 4'd0;
  localparam logic [3:0] st_tag_check     = 4'd1;
  localparam logic [3:0] st_read_access   = 4'd2;
  localparam logic [3:0] st_write_access  = 4'd3;
  localparam logic [3:0] st_resp          = 4'd4;
  localparam logic [3:0] st_refill_req    = 4'd5;
  localparam logic [3:0] st_refill_wait   = 4'd6;
  localparam logic [3:0] st_refill_update = 4'd7;
  localparam logic [3:0] st_evict_prepare = 4'd8;
  localparam logic [3:0] st_evict_req     = 4'd9;
  localparam logic [3:0] st_evict_wait    = 4'd10;
  localparam logic [3:0] st_amo_read      = 4'd11;
  localparam logic [3:0] st_amo_write     = 4'd12;
  localparam logic [3:0] st_init_access   = 4'd13;

  logic [3:0] state_reg;
  logic [3:0] state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_reg <= st_idle;
    end else begin
      state_reg <= state_next;
    end
  end

  // ----------------------------------------------------------------------------
  // request decode
  // ----------------------------------------------------------------------------

  logic in_go;
  logic out_go;
  logic hit;
  logic is_read;
  logic is_write;
  logic is_init;
  logic is_amo;

  assign in_go    = cachereq_val && cachereq_rdy;
  assign out_go   = cacheresp_val && cacheresp_rdy;
  // dirty implies valid, so a dirty miss always has a victim to write back
  assign hit      = is_valid && tag_match;
  assign is_read  = req_type == cache_pkg::type_read;
  assign is_write = req_type == cache_pkg::type_write;
  assign is_init  = req_type == cache_pkg::type_write_init;
  assign is_amo   = amo_op != cache_pkg::amo_none;

  always_comb begin
    case (req_type)
      cache_pkg::type_amo_add: amo_op = cache_pkg::amo_add;
      cache_pkg::type_amo_and: amo_op = cache_pkg::amo_and;
      cache_pkg::type_amo_or:  amo_op = cache_pkg::amo_or;
      default:                 amo_op = cache_pkg::amo_none;
    endcase
  end

  // ----------------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------------

  always_comb begin
    state_next = state_reg;
    case (state_reg)
      st_idle:
        if (in_go) state_next = st_tag_check;
      st_tag_check:
        // write-init takes the block whatever it held
        if (is_init) state_next = st_init_access;
        else if (hit && is_read) state_next = st_read_access;
        else if (hit && is_write) state_next = st_write_access;
        else if (hit && is_amo) state_next = st_amo_read;
        else if (is_dirty) state_next = st_evict_prepare;
        else state_next = st_refill_req;
      st_read_access, st_write_access, st_init_access, st_amo_write:
        state_next = st_resp;
      st_amo_read:
        state_next = st_amo_write;
      st_refill_req:
        if (memreq_rdy) state_next = st_refill_wait;
      st_refill_wait:
        if (memresp_val) state_next = st_refill_update;
      st_refill_update:
        // replay the access now that the line is present
        if (is_read) state_next = st_read_access;
        else if (is_write) state_next = st_write_access;
        else state_next = st_amo_read;
      st_evict_prepare:
        state_next = st_evict_req;
      st_evict_req:
        if (memreq_rdy) state_next = st_evict_wait;
      st_evict_wait:
        // write ack received, go fetch the new line
        if (memresp_val) state_next = st_refill_req;
      st_resp:
        if (out_go) state_next = st_idle;
      default:
        state_next = st_idle;
    endcase
  end

  // ----------------------------------------------------------------------------
  // control table
  // ----------------------------------------------------------------------------

  logic [17:0] cs;
  logic        mem_write;

  // columns, left to right
  //   a cachereq_rdy      b cacheresp_val     c memreq_val       d memresp_rdy
  //   e cachereq_en       f memresp_en        g is_refill        h tag_array_wen
  //   i tag_array_ren     j data_array_wen    k data_array_ren   l read_data_reg_en
  //   m read_tag_reg_en   n mem_write         o valid_wen        p valid_in
  //   q dirty_wen         r dirty_in
  always_comb begin
    case (state_reg)
      //                          a b c d e f g h i j k l m n o p q r
      st_idle:          cs = 18'b1_0_0_0_1_0_0_0_0_0_0_0_0_0_0_0_0_0;
      st_tag_check:     cs = 18'b0_0_0_0_0_0_0_0_1_0_0_0_0_0_0_0_0_0;
      st_read_access:   cs = 18'b0_0_0_0_0_0_0_0_0_0_1_1_0_0_0_0_0_0;
      st_write_access:  cs = 18'b0_0_0_0_0_0_0_1_0_1_0_0_0_0_1_1_1_1;
      st_init_access:   cs = 18'b0_0_0_0_0_0_0_1_0_1_0_0_0_0_1_1_1_0;
      st_amo_read:      cs = 18'b0_0_0_0_0_0_0_0_0_0_1_1_0_0_0_0_0_0;
      st_amo_write:     cs = 18'b0_0_0_0_0_0_0_1_0_1_0_0_0_0_1_1_1_1;
      st_refill_req:    cs = 18'b0_0_1_0_0_0_0_0_0_0_0_0_0_0_0_0_0_0;
      st_refill_wait:   cs = 18'b0_0_0_1_0_1_0_0_0_0_0_0_0_0_0_0_0_0;
      st_refill_update: cs = 18'b0_0_0_0_0_0_1_1_0_1_0_0_0_0_1_1_1_0;
      st_evict_prepare: cs = 18'b0_0_0_0_0_0_0_0_1_0_1_1_1_0_0_0_0_0;
      st_evict_req:     cs = 18'b0_0_1_0_0_0_0_0_0_0_0_0_0_1_0_0_0_0;
      st_evict_wait:    cs = 18'b0_0_0_1_0_0_0_0_0_0_0_0_0_1_0_0_0_0;
      st_resp:          cs = 18'b0_1_0_0_0_0_0_0_0_0_0_0_0_0_0_0_0_0;
      default:          cs = 18'b0_0_0_0_0_0_0_0_0_0_0_0_0_0_0_0_0_0;
    endcase
  end

  assign {cachereq_rdy, cacheresp_val, memreq_val, memresp_rdy,
          cachereq_en, memresp_en, is_refill, tag_array_wen,
          tag_array_ren, data_array_wen, data_array_ren, read_data_reg_en,
          read_tag_reg_en, mem_write, valid_wen, valid_in,
          dirty_wen, dirty_in} = cs;

  // evictions write the victim line, refills read the requested one
  assign memreq_type = mem_write ? cache_pkg::type_write : cache_pkg::type_read;

endmodule

// File: cache_pkg.sv
/*
 * cache package
 * message widths, request type codes and the atomic operation encoding
 */
package cache_pkg;

  // ----------------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------------

  localparam int addr_nbits     = 32;
  localparam int data_nbits     = 32;
  localparam int line_nbits     = 128;
  localparam int opaque_nbits   = 8;
  localparam int words_per_line = line_nbits / data_nbits;

  // ----------------------------------------------------------------------------
  // message types
  // ----------------------------------------------------------------------------

  // processor requests use all six, memory messages only read and write
  typedef enum logic [2:0] {
    type_read       = 3'd0,
    type_write      = 3'd1,
    type_write_init = 3'd2,
    type_amo_add    = 3'd3,
    type_amo_and    = 3'd4,
    type_amo_or     = 3'd5
  } req_type_t;

  // atomic selector, decoded from the request type by the FSM
  typedef enum logic [1:0] {
    amo_none = 2'd0,
    amo_add  = 2'd1,
    amo_and  = 2'd2,
    amo_or   = 2'd3
  } amo_op_t;

endpackage
